// File: verilog/cu_macros.svh
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// opcode field width, also used for the alu operation
`define CU_OPCODE_W 5

// pc mux select width
`define CU_PCSEL_W 2

// memory write data mux select width
`define CU_MDSEL_W 2

// empty cycles between the control freeze and the first interrupt push
// the interrupt sequencer accepts any value, zero included
`define CU_INT_DRAIN 2

`endif

// File: verilog/cu_pkg.sv
`default_nettype none

`include "cu_macros.svh"

package cu_pkg;

  typedef enum logic [`CU_OPCODE_W-1:0] {
    OP_NOP  = 5'b00000,
    OP_NOT  = 5'b00011,
    OP_INC  = 5'b00100,
    OP_DEC  = 5'b00101,
    OP_OUT  = 5'b00110,
    OP_PUSH = 5'b00111,
    OP_MOV  = 5'b01000,
    OP_ADD  = 5'b01001,
    OP_AND  = 5'b01010,
    OP_OR   = 5'b01011,
    OP_SUB  = 5'b01100,
    OP_IADD = 5'b01101,
    OP_SHL  = 5'b01110,
    OP_IN   = 5'b01111,
    OP_POP  = 5'b10000,
    OP_LDM  = 5'b10001,
    OP_LDD  = 5'b10010,
    OP_STD  = 5'b10011,
    OP_JZ   = 5'b10100,
    OP_JN   = 5'b10101,
    OP_JC   = 5'b10110,
    OP_JMP  = 5'b10111,
    OP_CALL = 5'b11000,
    OP_RET  = 5'b11001,
    OP_RTI  = 5'b11010
  } opcode_e;

  typedef enum logic [`CU_PCSEL_W-1:0] {
    PC_NEXT   = 2'd0,
    PC_RESET  = 2'd1,
    PC_VECTOR = 2'd2,
    PC_TARGET = 2'd3
  } pc_sel_e;

  typedef enum logic [`CU_MDSEL_W-1:0] {
    MD_DATA = 2'd0,
    MD_PC1  = 2'd1,
    MD_PC2  = 2'd2,
    MD_CCR  = 2'd3
  } mem_data_sel_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CALL2,
    S_RET2,
    S_RTI1,
    S_RTI2,
    S_RTI3
  } stack_state_e;

  typedef enum logic [3:0] {
    I_IDLE,
    I_ACK,
    I_HAZARD,
    I_FREEZE_PC,
    I_FREEZE_CU,
    I_DRAIN,
    I_PUSH_PC1,
    I_PUSH_PC2,
    I_PUSH_CCR
  } int_state_e;

  // datapath controls of one instruction
  typedef struct packed {
    logic [`CU_OPCODE_W-1:0] alu_op;
    logic [1:0]              alu_src;
    logic                    reg_wr;
    logic                    mem_rd;
    logic                    mem_wr;
    logic                    mem_to_reg;
    logic                    stack;
    logic                    ldm;
    logic                    port_rd;
    logic                    port_wr;
    logic                    branch;
    logic                    call;
    logic                    ret;
    logic                    rti;
  } decode_t;

  // per cycle outputs of a stack or interrupt sequence
  typedef struct packed {
    logic    mem_rd;
    logic    mem_wr;
    logic    stack;
    logic    pc_to_stack1;
    logic    pc_to_stack2;
    logic    ccr_to_stack;
    logic    pop_pc1;
    logic    pop_pc2;
    logic    pop_ccr;
    logic    freeze_pc;
    logic    freeze_cu;
    logic    flush;
    pc_sel_e pc_sel;
  } seq_t;

endpackage

`default_nettype wire

// File: verilog/opcode_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decoder (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire cu_pkg::opcode_e opcode,
  output cu_pkg::decode_t      dec,
  output logic                 ldm_freeze,
  output logic                 ldm_value
);

  // high in the cycle after an ldm has frozen the front end
  logic ldm_phase;

  always_comb
  begin
    dec        = '0;
    dec.alu_op = opcode;
    case (opcode)
      cu_pkg::OP_NOT, cu_pkg::OP_INC, cu_pkg::OP_DEC,
      cu_pkg::OP_MOV, cu_pkg::OP_ADD, cu_pkg::OP_AND,
      cu_pkg::OP_OR, cu_pkg::OP_SUB:
        dec.reg_wr = 1'b1;
      cu_pkg::OP_IADD, cu_pkg::OP_SHL:
      begin
        dec.reg_wr  = 1'b1;
        // immediate operand on the second alu input
        dec.alu_src = 2'b01;
      end
      cu_pkg::OP_IN:
      begin
        dec.reg_wr  = 1'b1;
        dec.port_rd = 1'b1;
      end
      cu_pkg::OP_OUT:
        dec.port_wr = 1'b1;
      cu_pkg::OP_PUSH:
      begin
        dec.mem_wr = 1'b1;
        dec.stack  = 1'b1;
      end
      cu_pkg::OP_POP:
      begin
        dec.reg_wr     = 1'b1;
        dec.mem_rd     = 1'b1;
        dec.mem_to_reg = 1'b1;
        dec.stack      = 1'b1;
      end
      cu_pkg::OP_LDM:
      begin
        dec.reg_wr  = 1'b1;
        dec.ldm     = 1'b1;
        dec.alu_src = 2'b10;
      end
      cu_pkg::OP_LDD:
      begin
        dec.reg_wr     = 1'b1;
        dec.mem_rd     = 1'b1;
        dec.mem_to_reg = 1'b1;
      end
      cu_pkg::OP_STD:
        dec.mem_wr = 1'b1;
      cu_pkg::OP_JZ, cu_pkg::OP_JN, cu_pkg::OP_JC, cu_pkg::OP_JMP:
        dec.branch = 1'b1;
      cu_pkg::OP_CALL:
        dec.call = 1'b1;
      cu_pkg::OP_RET:
        dec.ret = 1'b1;
      cu_pkg::OP_RTI:
        dec.rti = 1'b1;
      // nop and unused codes leave the word cleared
      default:
        ;
    endcase
  end

  // first ldm cycle freezes while the immediate word is fetched
  assign ldm_freeze = dec.ldm & ~ldm_phase;
  assign ldm_value  = ldm_phase;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ldm_phase <= 1'b0;
    else
      ldm_phase <= ldm_freeze;
  end

endmodule

`default_nettype wire

// File: verilog/stack_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stack_sequencer (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire cu_pkg::decode_t dec,
  output cu_pkg::seq_t         stk
);

  cu_pkg::stack_state_e state;
  cu_pkg::stack_state_e state_nxt;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= cu_pkg::S_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    stk       = '0;
    state_nxt = cu_pkg::S_IDLE;
    case (state)
      cu_pkg::S_IDLE:
      begin
        if (dec.call)
        begin
          // low half of the return address goes first, fetch jumps now
          stk.mem_wr       = 1'b1;
          stk.stack        = 1'b1;
          stk.pc_to_stack1 = 1'b1;
          stk.pc_sel       = cu_pkg::PC_TARGET;
          state_nxt        = cu_pkg::S_CALL2;
        end
        else if (dec.ret)
        begin
          stk.mem_rd    = 1'b1;
          stk.stack     = 1'b1;
          stk.pop_pc2   = 1'b1;
          stk.freeze_pc = 1'b1;
          stk.freeze_cu = 1'b1;
          state_nxt     = cu_pkg::S_RET2;
        end
        else if (dec.rti)
        begin
          // rti waits one cycle before the first pop
          state_nxt = cu_pkg::S_RTI1;
        end
      end
      cu_pkg::S_CALL2:
      begin
        stk.mem_wr       = 1'b1;
        stk.stack        = 1'b1;
        stk.pc_to_stack2 = 1'b1;
        stk.flush        = 1'b1;
      end
      cu_pkg::S_RET2:
      begin
        stk.mem_rd  = 1'b1;
        stk.stack   = 1'b1;
        stk.pop_pc1 = 1'b1;
        stk.flush   = 1'b1;
        stk.pc_sel  = cu_pkg::PC_TARGET;
      end
      cu_pkg::S_RTI1:
      begin
        stk.mem_rd    = 1'b1;
        stk.stack     = 1'b1;
        stk.freeze_pc = 1'b1;
        stk.freeze_cu = 1'b1;
        stk.pop_ccr   = 1'b1;
        state_nxt     = cu_pkg::S_RTI2;
      end
      cu_pkg::S_RTI2:
      begin
        stk.mem_rd    = 1'b1;
        stk.stack     = 1'b1;
        stk.freeze_pc = 1'b1;
        stk.freeze_cu = 1'b1;
        stk.pop_pc2   = 1'b1;
        state_nxt     = cu_pkg::S_RTI3;
      end
      cu_pkg::S_RTI3:
      begin
        stk.mem_rd    = 1'b1;
        stk.stack     = 1'b1;
        stk.freeze_pc = 1'b1;
        stk.freeze_cu = 1'b1;
        stk.pop_pc1   = 1'b1;
        stk.pc_sel    = cu_pkg::PC_TARGET;
      end
      default:
        state_nxt = cu_pkg::S_IDLE;
    endcase
  end

  // the decoder must never raise two stack requests at once
  one_stack_request: assert property (@(posedge clk) disable iff (rst)
    $onehot0({dec.call, dec.ret, dec.rti}));

endmodule

`default_nettype wire

// File: verilog/interrupt_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cu_macros.svh"

module interrupt_sequencer (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire logic            interrupt,
  input  wire logic            branch_taken,
  input  wire logic            load_use,
  input  wire cu_pkg::decode_t dec,
  output cu_pkg::seq_t         irq,
  output logic                 ack
);

  localparam int DRAIN = `CU_INT_DRAIN;
  localparam int CNT_W = (DRAIN > 1) ? $clog2(DRAIN) : 1;
  // worst case from ack to the flags push, hazard cycle included
  localparam int MAX_LAT = DRAIN + 6;

  cu_pkg::int_state_e state;
  cu_pkg::int_state_e state_nxt;
  logic [CNT_W-1:0]   drain_cnt;
  logic               int_q;
  logic               int_rise;

  assign int_rise = interrupt & ~int_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state     <= cu_pkg::I_IDLE;
      int_q     <= 1'b0;
      drain_cnt <= '0;
    end
    else
    begin
      state <= state_nxt;
      int_q <= interrupt;
      if (state == cu_pkg::I_DRAIN)
        drain_cnt <= drain_cnt + 1'b1;
      else
        drain_cnt <= '0;
    end
  end

  always_comb
  begin
    irq       = '0;
    ack       = 1'b0;
    state_nxt = state;
    case (state)
      cu_pkg::I_IDLE:
      begin
        if (int_rise)
        begin
          // a taken branch must still load its target this cycle
          irq.freeze_pc = ~branch_taken;
          state_nxt     = cu_pkg::I_ACK;
        end
      end
      cu_pkg::I_ACK:
      begin
        ack           = 1'b1;
        irq.freeze_pc = ~branch_taken;
        if (dec.ldm || load_use)
          state_nxt = cu_pkg::I_HAZARD;
        else
          state_nxt = cu_pkg::I_FREEZE_PC;
      end
      cu_pkg::I_HAZARD:
      begin
        irq.freeze_pc = 1'b1;
        state_nxt     = cu_pkg::I_FREEZE_PC;
      end
      cu_pkg::I_FREEZE_PC:
      begin
        irq.freeze_pc = 1'b1;
        state_nxt     = cu_pkg::I_FREEZE_CU;
      end
      cu_pkg::I_FREEZE_CU:
      begin
        irq.freeze_pc = 1'b1;
        irq.freeze_cu = 1'b1;
        state_nxt     = (DRAIN == 0) ? cu_pkg::I_PUSH_PC1 : cu_pkg::I_DRAIN;
      end
      cu_pkg::I_DRAIN:
      begin
        irq.freeze_pc = 1'b1;
        if (drain_cnt == CNT_W'(DRAIN - 1))
          state_nxt = cu_pkg::I_PUSH_PC1;
      end
      cu_pkg::I_PUSH_PC1:
      begin
        irq.freeze_pc    = 1'b1;
        irq.mem_wr       = 1'b1;
        irq.stack        = 1'b1;
        irq.pc_to_stack1 = 1'b1;
        state_nxt        = cu_pkg::I_PUSH_PC2;
      end
      cu_pkg::I_PUSH_PC2:
      begin
        irq.freeze_pc    = 1'b1;
        irq.mem_wr       = 1'b1;
        irq.stack        = 1'b1;
        irq.pc_to_stack2 = 1'b1;
        state_nxt        = cu_pkg::I_PUSH_CCR;
      end
      cu_pkg::I_PUSH_CCR:
      begin
        // fetch is released and steered to the handler
        irq.mem_wr       = 1'b1;
        irq.stack        = 1'b1;
        irq.ccr_to_stack = 1'b1;
        irq.pc_sel       = cu_pkg::PC_VECTOR;
        state_nxt        = cu_pkg::I_IDLE;
      end
      default:
        state_nxt = cu_pkg::I_IDLE;
    endcase
  end

  ack_then_ccr_push: assert property (@(posedge clk) disable iff (rst)
    ack |-> ##[1:MAX_LAT] irq.ccr_to_stack);

endmodule

`default_nettype wire

// File: verilog/control_merge.sv
`timescale 1ns/1ps
`default_nettype none

module control_merge (
  input  wire logic            rst,
  input  wire cu_pkg::decode_t dec,
  input  wire cu_pkg::seq_t    stk,
  input  wire cu_pkg::seq_t    irq,
  input  wire logic            ldm_freeze,
  input  wire logic            load_use,
  input  wire logic            branch_taken,
  output cu_pkg::decode_t      ctrl,
  output cu_pkg::seq_t         stack_ctl,
  output logic                 freeze_cu,
  output logic                 fetch_pc_enable,
  output logic                 flush,
  output cu_pkg::pc_sel_e      pc_sel,
  output cu_pkg::mem_data_sel_e mem_data_sel
);

  always_comb
  begin
    ctrl            = '0;
    stack_ctl       = '0;
    freeze_cu       = 1'b0;
    flush           = 1'b0;
    fetch_pc_enable = 1'b1;
    pc_sel          = cu_pkg::PC_RESET;
    mem_data_sel    = cu_pkg::MD_DATA;
    if (!rst)
    begin
      // sequencer memory accesses share the instruction's memory port
      ctrl        = dec;
      ctrl.mem_rd = dec.mem_rd | stk.mem_rd | irq.mem_rd;
      ctrl.mem_wr = dec.mem_wr | stk.mem_wr | irq.mem_wr;
      ctrl.stack  = dec.stack | stk.stack | irq.stack;

      stack_ctl        = cu_pkg::seq_t'(stk | irq);
      stack_ctl.pc_sel = (irq.pc_sel != cu_pkg::PC_NEXT) ? irq.pc_sel : stk.pc_sel;

      freeze_cu       = load_use | ldm_freeze | stk.freeze_cu | irq.freeze_cu;
      flush           = branch_taken | stk.flush | irq.flush;
      fetch_pc_enable = ~(stk.freeze_pc | irq.freeze_pc);

      if (stack_ctl.pc_sel != cu_pkg::PC_NEXT)
        pc_sel = stack_ctl.pc_sel;
      else if (branch_taken)
        pc_sel = cu_pkg::PC_TARGET;
      else
        pc_sel = cu_pkg::PC_NEXT;

      if (stack_ctl.pc_to_stack1)
        mem_data_sel = cu_pkg::MD_PC1;
      else if (stack_ctl.pc_to_stack2)
        mem_data_sel = cu_pkg::MD_PC2;
      else if (stack_ctl.ccr_to_stack)
        mem_data_sel = cu_pkg::MD_CCR;
    end
  end

  // both sequencers on the stack port at once would corrupt a push or pop
  no_port_clash: assert final (rst ||
    !((stk.mem_wr || stk.mem_rd) && (irq.mem_wr || irq.mem_rd)))
    else $error("stack and interrupt sequencers drive memory together");

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire cu_pkg::opcode_e opcode,
  input  wire logic            interrupt,
  input  wire logic            load_use,
  input  wire logic            branch_taken,
  output cu_pkg::decode_t      ctrl,
  output cu_pkg::seq_t         stack_ctl,
  output logic                 ldm_value,
  output logic                 ack,
  output logic                 freeze_cu,
  output logic                 fetch_pc_enable,
  output logic                 flush,
  output cu_pkg::pc_sel_e      pc_sel,
  output cu_pkg::mem_data_sel_e mem_data_sel
);

  cu_pkg::decode_t dec;
  cu_pkg::seq_t    stk;
  cu_pkg::seq_t    irq;
  logic            ldm_freeze;

  opcode_decoder decode_i (
    .clk        (clk),
    .rst        (rst),
    .opcode     (opcode),
    .dec        (dec),
    .ldm_freeze (ldm_freeze),
    .ldm_value  (ldm_value)
  );

  stack_sequencer stack_seq_i (
    .clk (clk),
    .rst (rst),
    .dec (dec),
    .stk (stk)
  );

  interrupt_sequencer int_seq_i (
    .clk          (clk),
    .rst          (rst),
    .interrupt    (interrupt),
    .branch_taken (branch_taken),
    .load_use     (load_use),
    .dec          (dec),
    .irq          (irq),
    .ack          (ack)
  );

  control_merge merge_i (
    .rst             (rst),
    .dec             (dec),
    .stk             (stk),
    .irq             (irq),
    .ldm_freeze      (ldm_freeze),
    .load_use        (load_use),
    .branch_taken    (branch_taken),
    .ctrl            (ctrl),
    .stack_ctl       (stack_ctl),
    .freeze_cu       (freeze_cu),
    .fetch_pc_enable (fetch_pc_enable),
    .flush           (flush),
    .pc_sel          (pc_sel),
    .mem_data_sel    (mem_data_sel)
  );

endmodule

`default_nettype wire

// File: verif/control_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cu_macros.svh"

module control_unit_tb;

  localparam int TIMEOUT = 32;

  // one clock of stimulus together with the outputs expected in that clock
  typedef struct packed {
    cu_pkg::opcode_e       opcode;
    logic [2:0]            inputs;
    cu_pkg::seq_t          stack_ctl;
    logic [2:0]            flags;
    cu_pkg::pc_sel_e       pc_sel;
    cu_pkg::mem_data_sel_e mem_data_sel;
    logic                  ldm_value;
    logic                  last;
  } row_t;

  logic                  clk = 1'b0;
  logic                  rst;
  cu_pkg::opcode_e       opcode;
  logic                  interrupt;
  logic                  load_use;
  logic                  branch_taken;
  cu_pkg::decode_t       ctrl;
  cu_pkg::seq_t          stack_ctl;
  logic                  ldm_value;
  logic                  ack;
  logic                  freeze_cu;
  logic                  fetch_pc_enable;
  logic                  flush;
  cu_pkg::pc_sel_e       pc_sel;
  cu_pkg::mem_data_sel_e mem_data_sel;

  row_t  rows[$];
  string row_names[$];
  int    tests = 0;
  int    checks = 0;
  int    errors = 0;

  always #20 clk = ~clk;

  control_unit dut_i (
    .clk             (clk),
    .rst             (rst),
    .opcode          (opcode),
    .interrupt       (interrupt),
    .load_use        (load_use),
    .branch_taken    (branch_taken),
    .ctrl            (ctrl),
    .stack_ctl       (stack_ctl),
    .ldm_value       (ldm_value),
    .ack             (ack),
    .freeze_cu       (freeze_cu),
    .fetch_pc_enable (fetch_pc_enable),
    .flush           (flush),
    .pc_sel          (pc_sel),
    .mem_data_sel    (mem_data_sel)
  );

  // inputs change on the rising edge, outputs are looked at on the falling edge
  task automatic drive_cycle(input cu_pkg::opcode_e op, input logic intr, input logic lu,
                             input logic bt);
    @(posedge clk);
    opcode       <= op;
    interrupt    <= intr;
    load_use     <= lu;
    branch_taken <= bt;
    @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  task automatic check_reset_values();
    check_value("ctrl", ctrl, '0);
    check_value("stack_ctl", stack_ctl, '0);
    check_value("ack", ack, 1'b0);
    check_value("ldm_value", ldm_value, 1'b0);
    check_value("freeze_cu", freeze_cu, 1'b0);
    check_value("flush", flush, 1'b0);
    check_value("fetch_pc_enable", fetch_pc_enable, 1'b1);
    check_value("pc_sel", pc_sel, cu_pkg::PC_RESET);
    check_value("mem_data_sel", mem_data_sel, cu_pkg::MD_DATA);
  endtask

  // NOPs until every sequence has ended, then a few random extra NOPs
  task automatic idle_gap();
    int waited;
    waited = 0;
    drive_cycle(cu_pkg::OP_NOP, 1'b0, 1'b0, 1'b0);
    while ((stack_ctl != '0 || freeze_cu || ldm_value || ack || !fetch_pc_enable)
           && waited < TIMEOUT)
    begin
      drive_cycle(cu_pkg::OP_NOP, 1'b0, 1'b0, 1'b0);
      waited++;
    end
    if (waited == TIMEOUT)
      note_failure("control unit did not return to idle");
    repeat ($urandom % 3 + 1)
      drive_cycle(cu_pkg::OP_NOP, 1'b0, 1'b0, 1'b0);
  endtask

  // decode word of one instruction, built from the instruction set rules
  function automatic cu_pkg::decode_t decode_rule(input cu_pkg::opcode_e op);
    cu_pkg::decode_t d;
    logic [4:0]      code;
    code         = op;
    d            = '0;
    d.alu_op     = code;
    d.branch     = (code[4:2] == 3'b101);
    d.call       = (op == cu_pkg::OP_CALL);
    d.ret        = (op == cu_pkg::OP_RET);
    d.rti        = (op == cu_pkg::OP_RTI);
    d.ldm        = (op == cu_pkg::OP_LDM);
    d.port_rd    = (op == cu_pkg::OP_IN);
    d.port_wr    = (op == cu_pkg::OP_OUT);
    d.mem_rd     = (op == cu_pkg::OP_POP) || (op == cu_pkg::OP_LDD);
    d.mem_to_reg = d.mem_rd;
    d.mem_wr     = (op == cu_pkg::OP_PUSH) || (op == cu_pkg::OP_STD);
    d.stack      = (op == cu_pkg::OP_PUSH) || (op == cu_pkg::OP_POP);
    // single operand and register ops, IN, and the loads into a register
    d.reg_wr     = (code >= 5'b00011 && code <= 5'b01111 && op != cu_pkg::OP_OUT
                    && op != cu_pkg::OP_PUSH) || d.mem_rd || d.ldm;
    if (op == cu_pkg::OP_IADD || op == cu_pkg::OP_SHL)
      d.alu_src = 2'b01;
    else if (op == cu_pkg::OP_LDM)
      d.alu_src = 2'b10;
    return d;
  endfunction

  task automatic add_row(input string name, input logic last, input cu_pkg::opcode_e op,
                         input logic [2:0] inputs, input cu_pkg::seq_t stk,
                         input logic [2:0] flags, input cu_pkg::pc_sel_e pcs,
                         input cu_pkg::mem_data_sel_e mds, input logic ldmv);
    row_t r;
    r.opcode       = op;
    r.inputs       = inputs;
    r.stack_ctl    = stk;
    r.flags        = flags;
    r.pc_sel       = pcs;
    r.mem_data_sel = mds;
    r.ldm_value    = ldmv;
    r.last         = last;
    rows.push_back(r);
    row_names.push_back(name);
  endtask

  // inputs are {interrupt, load_use, branch_taken}
  // stack_ctl bits: rd wr st, p1 p2 ccr, pop1 pop2 popccr, frz_pc frz_cu flush, pc_sel
  // flags are {freeze_cu, flush, fetch_pc_enable}
  task automatic build_table();
    add_row("ldm", 0, cu_pkg::OP_LDM, 3'b000, 14'b000_000_000_000_00, 3'b101,
            cu_pkg::PC_NEXT, cu_pkg::MD_DATA, 1'b0);
    add_row("ldm", 1, cu_pkg::OP_NOP, 3'b000, 14'b000_000_000_000_00, 3'b001,
            cu_pkg::PC_NEXT, cu_pkg::MD_DATA, 1'b1);
    add_row("call", 0, cu_pkg::OP_CALL, 3'b000, 14'b011_100_000_000_11, 3'b001,
            cu_pkg::PC_TARGET, cu_pkg::MD_PC1, 1'b0);
    add_row("call", 1, cu_pkg::OP_NOP, 3'b000, 14'b011_010_000_001_00, 3'b011,
            cu_pkg::PC_NEXT, cu_pkg::MD_PC2, 1'b0);
    add_row("ret", 0, cu_pkg::OP_RET, 3'b000, 14'b101_000_010_110_00, 3'b100,
            cu_pkg::PC_NEXT, cu_pkg::MD_DATA, 1'b0);
    add_row("ret", 1, cu_pkg::OP_RET, 3'b000, 14'b101_000_100_001_11, 3'b011,
            cu_pkg::PC_TARGET, cu_pkg::MD_DATA, 1'b0);
    add_row("rti", 0, cu_pkg::OP_RTI, 3'b000, 14'b000_000_000_000_00, 3'b001,
            cu_pkg::PC_NEXT, cu_pkg::MD_DATA, 1'b0);
    // a CALL held during the pops must not start a push
    add_row("rti", 0, cu_pkg::OP_CALL, 3'b000, 14'b101_000_001_110_00, 3'b100,
            cu_pkg::PC_NEXT, cu_pkg::MD_DATA, 1'b0);
    add_row("rti", 0, cu_pkg::OP_CALL, 3'b000, 14'b101_000_010_110_00, 3'b100,
            cu_pkg::PC_NEXT, cu_pkg::MD_DATA, 1'b0);
    add_row("rti", 1, cu_pkg::OP_CALL, 3'b000, 14'b101_000_100_110_11, 3'b100,
            cu_pkg::PC_TARGET, cu_pkg::MD_DATA, 1'b0);
    add_row("branch", 1, cu_pkg::OP_JZ, 3'b001, 14'b000_000_000_000_00, 3'b011,
            cu_pkg::PC_TARGET, cu_pkg::MD_DATA, 1'b0);
  endtask

  task automatic run_interrupt(input string name, input logic hazard, input logic branch,
                               output int latency);
    int                    errors_before;
    int                    waited;
    int                    freezes;
    cu_pkg::mem_data_sel_e pushes[$];
    errors_before = errors;
    latency       = -1;
    freezes       = 0;
    // request cycle, fetch keeps running only for a taken branch
    drive_cycle(cu_pkg::OP_NOP, 1'b1, 1'b0, branch);
    check_value("fetch_pc_enable", fetch_pc_enable, branch);
    check_value("ack", ack, 1'b0);
    drive_cycle(cu_pkg::OP_NOP, 1'b0, hazard, 1'b0);
    waited = 0;
    while (!ack && waited < TIMEOUT)
    begin
      drive_cycle(cu_pkg::OP_NOP, 1'b0, hazard, 1'b0);
      waited++;
    end
    if (!ack)
    begin
      note_failure("interrupt was never acknowledged");
      report_test(name, errors_before);
      return;
    end
    check_value("fetch_pc_enable", fetch_pc_enable, 1'b0);
    latency = 0;
    while (!stack_ctl.ccr_to_stack && latency < TIMEOUT)
    begin
      drive_cycle(cu_pkg::OP_NOP, 1'b0, 1'b0, 1'b0);
      latency++;
      check_value("ack", ack, 1'b0);
      if (freeze_cu)
        freezes++;
      if (stack_ctl.mem_wr)
        pushes.push_back(mem_data_sel);
      if (!stack_ctl.ccr_to_stack)
        check_value("fetch_pc_enable", fetch_pc_enable, 1'b0);
    end
    if (!stack_ctl.ccr_to_stack)
      note_failure("flags push never followed the interrupt acknowledge");
    else
    begin
      check_value("pc_sel", pc_sel, cu_pkg::PC_VECTOR);
      check_value("fetch_pc_enable", fetch_pc_enable, 1'b1);
      // optional hazard, freeze pc, freeze cu, drain, then the three pushes
      check_value("ack to ccr push latency", latency, `CU_INT_DRAIN + 5 + hazard);
      check_value("freeze_cu cycles", freezes, 1);
      check_value("push count", pushes.size(), 3);
      if (pushes.size() == 3)
      begin
        check_value("mem_data_sel push 1", pushes[0], cu_pkg::MD_PC1);
        check_value("mem_data_sel push 2", pushes[1], cu_pkg::MD_PC2);
        check_value("mem_data_sel push 3", pushes[2], cu_pkg::MD_CCR);
      end
    end
    report_test(name, errors_before);
  endtask

  initial
  begin
    int              errors_before;
    int              i;
    int              lat_plain;
    int              lat_hazard;
    int              lat_branch;
    cu_pkg::opcode_e op;
    cu_pkg::decode_t exp_dec;
    row_t            r;
    void'($urandom(52871));
    rst          = 1'b1;
    opcode       = cu_pkg::OP_NOP;
    interrupt    = 1'b0;
    load_use     = 1'b0;
    branch_taken = 1'b0;
    build_table();

    // requests during reset must not reach the outputs
    errors_before = errors;
    repeat (4)
    begin
      drive_cycle(cu_pkg::OP_LDM, 1'b0, 1'b0, 1'b1);
      check_reset_values();
    end
    @(posedge clk);
    rst          <= 1'b0;
    opcode       <= cu_pkg::OP_NOP;
    branch_taken <= 1'b0;
    @(negedge clk);
    report_test("reset", errors_before);
    idle_gap();

    errors_before = errors;
    op = op.first();
    for (i = 0; i < op.num(); i++)
    begin
      drive_cycle(op, 1'b0, 1'b0, 1'b0);
      exp_dec = decode_rule(op);
      // first cycle of call and ret already uses the stack port
      if (op == cu_pkg::OP_CALL)
      begin
        exp_dec.mem_wr = 1'b1;
        exp_dec.stack  = 1'b1;
      end
      if (op == cu_pkg::OP_RET)
      begin
        exp_dec.mem_rd = 1'b1;
        exp_dec.stack  = 1'b1;
      end
      check_value($sformatf("ctrl for %s", op.name()), ctrl, exp_dec);
      idle_gap();
      op = op.next();
    end
    report_test("decode", errors_before);

    errors_before = errors;
    for (i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      drive_cycle(r.opcode, r.inputs[2], r.inputs[1], r.inputs[0]);
      check_value("stack_ctl", stack_ctl, r.stack_ctl);
      check_value("freeze_cu", freeze_cu, r.flags[2]);
      check_value("flush", flush, r.flags[1]);
      check_value("fetch_pc_enable", fetch_pc_enable, r.flags[0]);
      check_value("pc_sel", pc_sel, r.pc_sel);
      check_value("mem_data_sel", mem_data_sel, r.mem_data_sel);
      check_value("ldm_value", ldm_value, r.ldm_value);
      check_value("ack", ack, 1'b0);
      if (r.last)
      begin
        report_test(row_names[i], errors_before);
        idle_gap();
        errors_before = errors;
      end
    end

    run_interrupt("interrupt", 1'b0, 1'b0, lat_plain);
    idle_gap();
    run_interrupt("interrupt_load_use", 1'b1, 1'b0, lat_hazard);
    idle_gap();
    run_interrupt("interrupt_branch", 1'b0, 1'b1, lat_branch);
    idle_gap();
    errors_before = errors;
    check_value("hazard latency over plain latency", lat_hazard, lat_plain + 1);
    // a taken branch in the request cycle does not stretch the sequence
    check_value("branch latency over plain latency", lat_branch, lat_plain);
    report_test("interrupt_latency", errors_before);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/cu_pkg.sv
verilog/opcode_decoder.sv
verilog/stack_sequencer.sv
verilog/interrupt_sequencer.sv
verilog/control_merge.sv
verilog/control_unit.sv
verif/control_unit_tb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cu_pkg.sv
      - verilog/opcode_decoder.sv
      - verilog/stack_sequencer.sv
      - verilog/interrupt_sequencer.sv
      - verilog/control_merge.sv
      - verilog/control_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/control_unit_tb.sv
